// File: build.f
cluster_bus_pkg.sv
cluster_bus_spill.sv
cluster_addr_decode.sv
cluster_bus_demux.sv
cluster_bus_mux.sv
cluster_bus_wrap.sv
tb_clk_gen.sv
tb_cluster_bus.sv

// File: cluster_addr_decode.sv
`timescale 1ns/1ps

module cluster_addr_decode #(
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] BASE_ADDR   = 32'h1000_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] PERIPH_OFFS = 32'h0020_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] EXT_OFFS    = 32'h0040_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] TCDM_SIZE   = 32'h0002_0000
) (
  input  logic [cluster_bus_pkg::CLUSTER_ID_W-1:0] cluster_id_i,
  input  logic [cluster_bus_pkg::ADDR_W-1:0]       addr_i,
  output cluster_bus_pkg::tgt_idx_t                tgt_o
);

  import cluster_bus_pkg::*;

  localparam int unsigned N_RULES = 4;

  // One address window, end is exclusive
  typedef struct packed {
    tgt_idx_t          idx;
    logic [ADDR_W-1:0] start_addr;
    logic [ADDR_W-1:0] end_addr;
  } rule_t;

  logic [ADDR_W-1:0]  cluster_base;
  rule_t [N_RULES-1:0] rules;

  // Each cluster owns a 4 MiB slot above the base
  assign cluster_base = BASE_ADDR + (ADDR_W'(cluster_id_i) << 22);

  assign rules[0] = '{idx: TGT_TCDM, start_addr: cluster_base,
                      end_addr: cluster_base + TCDM_SIZE};
  assign rules[1] = '{idx: TGT_PERIPH, start_addr: cluster_base + PERIPH_OFFS,
                      end_addr: cluster_base + EXT_OFFS};
  assign rules[2] = '{idx: TGT_EXT, start_addr: cluster_base + EXT_OFFS,
                      end_addr: '1};  // Above the cluster
  assign rules[3] = '{idx: TGT_EXT, start_addr: '0,
                      end_addr: cluster_base};  // Below the cluster

  // Lowest rule wins; gap after TCDM and the top word fall to external
  always_comb begin
    tgt_o = TGT_EXT;
    for (int i = N_RULES - 1; i >= 0; i--) begin
      if (addr_i >= rules[i].start_addr && addr_i < rules[i].end_addr) begin
        tgt_o = rules[i].idx;
      end
    end
  end

endmodule

// File: cluster_bus_demux.sv
`timescale 1ns/1ps

module cluster_bus_demux #(
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] BASE_ADDR   = 32'h1000_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] PERIPH_OFFS = 32'h0020_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] EXT_OFFS    = 32'h0040_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] TCDM_SIZE   = 32'h0002_0000,
  parameter int unsigned                        MAX_OUTST   = 4
) (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  logic [cluster_bus_pkg::CLUSTER_ID_W-1:0]            cluster_id_i,
  input  cluster_bus_pkg::ini_req_t                           ini_req_i,
  output cluster_bus_pkg::ini_rsp_t                           ini_rsp_o,
  output cluster_bus_pkg::ini_req_t [cluster_bus_pkg::NB_TGT-1:0] tgt_req_o,
  input  cluster_bus_pkg::ini_rsp_t [cluster_bus_pkg::NB_TGT-1:0] tgt_rsp_i
);

  import cluster_bus_pkg::*;

  localparam int unsigned CNT_W = $clog2(MAX_OUTST + 1);

  tgt_idx_t   dec_tgt;
  tgt_idx_t   lock_q;
  logic [CNT_W-1:0] cnt_q;
  logic       can_pass;
  logic       req_fire;
  logic       rsp_fire;

  cluster_addr_decode #(
    .BASE_ADDR   (BASE_ADDR),
    .PERIPH_OFFS (PERIPH_OFFS),
    .EXT_OFFS    (EXT_OFFS),
    .TCDM_SIZE   (TCDM_SIZE)
  ) u_decode (
    .cluster_id_i (cluster_id_i),
    .addr_i       (ini_req_i.req.addr),
    .tgt_o        (dec_tgt)
  );

  // Switching targets only once the pipe is empty keeps responses in order
  assign can_pass = (cnt_q == '0) ||
                    ((cnt_q < CNT_W'(MAX_OUTST)) && (dec_tgt == lock_q));

  always_comb begin
    for (int t = 0; t < NB_TGT; t++) begin
      tgt_req_o[t].req       = ini_req_i.req;
      tgt_req_o[t].req_valid = ini_req_i.req_valid && can_pass && (dec_tgt == tgt_idx_t'(t));
      tgt_req_o[t].rsp_ready = ini_req_i.rsp_ready && (lock_q == tgt_idx_t'(t));
    end
  end

  // Ready from the decoded target, response from the locked one
  always_comb begin
    ini_rsp_o = '0;
    for (int t = 0; t < NB_TGT; t++) begin
      if (dec_tgt == tgt_idx_t'(t)) begin
        ini_rsp_o.req_ready = can_pass && tgt_rsp_i[t].req_ready;
      end
      if (lock_q == tgt_idx_t'(t)) begin
        ini_rsp_o.rsp_valid = tgt_rsp_i[t].rsp_valid;
        ini_rsp_o.rsp       = tgt_rsp_i[t].rsp;
      end
    end
  end

  assign req_fire = ini_req_i.req_valid && ini_rsp_o.req_ready;
  assign rsp_fire = ini_rsp_o.rsp_valid && ini_req_i.rsp_ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      lock_q <= TGT_TCDM;
    end else begin
      if (req_fire && !rsp_fire) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!req_fire && rsp_fire) begin
        cnt_q <= cnt_q - 1'b1;
      end
      if (req_fire) begin
        lock_q <= dec_tgt;
      end
    end
  end

  // Responses only ever come back for requests this port issued
  a_no_stray_rsp : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ini_rsp_o.rsp_valid |-> cnt_q != '0
  ) else $error("response with no outstanding request");

endmodule

// File: cluster_bus_mux.sv
`timescale 1ns/1ps

module cluster_bus_mux (
  input  logic                                                clk_i,
  input  logic                                                rst_n_i,
  input  cluster_bus_pkg::ini_req_t [cluster_bus_pkg::NB_INI-1:0] ini_req_i,
  output cluster_bus_pkg::ini_rsp_t [cluster_bus_pkg::NB_INI-1:0] ini_rsp_o,
  output cluster_bus_pkg::tgt_req_t                           tgt_req_o,
  input  cluster_bus_pkg::tgt_rsp_t                           tgt_rsp_i
);

  import cluster_bus_pkg::*;

  logic [INI_IDX_W-1:0] rr_q;      // Highest priority this cycle
  logic [NB_INI-1:0]    gnt;
  logic [INI_IDX_W-1:0] gnt_idx;
  logic                 arb_valid;
  logic                 arb_ready;
  tgt_req_chan_t        arb_req;

  logic                 rsp_valid;
  logic                 rsp_ready;
  tgt_rsp_chan_t        rsp;
  logic [INI_IDX_W-1:0] rsp_dst;

  // Round-robin search starting at the pointer
  always_comb begin : arb
    int unsigned ini;
    gnt     = '0;
    gnt_idx = rr_q;
    for (int k = 0; k < NB_INI; k++) begin
      ini = (int'(rr_q) + k) % NB_INI;
      if (gnt == '0 && ini_req_i[ini].req_valid) begin
        gnt[ini] = 1'b1;
        gnt_idx  = INI_IDX_W'(ini);
      end
    end
  end

  assign arb_valid     = |gnt;
  assign arb_req.addr  = ini_req_i[gnt_idx].req.addr;
  assign arb_req.we    = ini_req_i[gnt_idx].req.we;
  assign arb_req.wdata = ini_req_i[gnt_idx].req.wdata;
  assign arb_req.be    = ini_req_i[gnt_idx].req.be;
  assign arb_req.id    = {gnt_idx, ini_req_i[gnt_idx].req.id};  // Tag with the source port

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (arb_valid && arb_ready) begin
      if (gnt_idx == INI_IDX_W'(NB_INI - 1)) begin
        rr_q <= '0;
      end else begin
        rr_q <= gnt_idx + 1'b1;
      end
    end
  end

  cluster_bus_spill #(
    .payload_t (tgt_req_chan_t)
  ) u_req_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (arb_valid),
    .ready_o (arb_ready),
    .data_i  (arb_req),
    .valid_o (tgt_req_o.req_valid),
    .ready_i (tgt_rsp_i.req_ready),
    .data_o  (tgt_req_o.req)
  );

  cluster_bus_spill #(
    .payload_t (tgt_rsp_chan_t)
  ) u_rsp_spill (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .valid_i (tgt_rsp_i.rsp_valid),
    .ready_o (tgt_req_o.rsp_ready),
    .data_i  (tgt_rsp_i.rsp),
    .valid_o (rsp_valid),
    .ready_i (rsp_ready),
    .data_o  (rsp)
  );

  // Upper ID bits name the initiator
  assign rsp_dst = rsp.id[ID_OUT_W-1 -: INI_IDX_W];

  always_comb begin
    rsp_ready = 1'b0;
    for (int i = 0; i < NB_INI; i++) begin
      ini_rsp_o[i].req_ready = gnt[i] && arb_ready;
      ini_rsp_o[i].rsp_valid = rsp_valid && (rsp_dst == INI_IDX_W'(i));
      ini_rsp_o[i].rsp.rdata = rsp.rdata;
      ini_rsp_o[i].rsp.id    = rsp.id[ID_IN_W-1:0];
      if (rsp_dst == INI_IDX_W'(i)) begin
        rsp_ready = ini_req_i[i].rsp_ready;   // Head of line blocks the rest
      end
    end
  end

  a_gnt_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt)
  ) else $error("more than one initiator granted");

endmodule

// File: cluster_bus_pkg.sv
package cluster_bus_pkg;

  // Bus dimensions
  localparam int unsigned ADDR_W       = 32;
  localparam int unsigned DATA_W       = 32;
  localparam int unsigned BE_W         = DATA_W / 8;
  localparam int unsigned ID_IN_W      = 4;   // ID width seen by the initiators
  localparam int unsigned NB_INI       = 4;   // Data, instr, DMA, external
  localparam int unsigned NB_TGT       = 3;   // TCDM, peripherals, external
  localparam int unsigned INI_IDX_W    = $clog2(NB_INI);
  localparam int unsigned ID_OUT_W     = ID_IN_W + INI_IDX_W;
  localparam int unsigned CLUSTER_ID_W = 6;

  // Target index, also the target port number in the crossbar
  typedef logic [1:0] tgt_idx_t;

  localparam tgt_idx_t TGT_TCDM   = 2'd0;
  localparam tgt_idx_t TGT_PERIPH = 2'd1;
  localparam tgt_idx_t TGT_EXT    = 2'd2;

  // Request payloads, identical apart from the ID width
  typedef struct packed {
    logic [ADDR_W-1:0]  addr;
    logic               we;
    logic [DATA_W-1:0]  wdata;
    logic [BE_W-1:0]    be;
    logic [ID_IN_W-1:0] id;
  } ini_req_chan_t;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                we;
    logic [DATA_W-1:0]   wdata;
    logic [BE_W-1:0]     be;
    logic [ID_OUT_W-1:0] id;   // Initiator index on top of the original ID
  } tgt_req_chan_t;

  // Response payloads
  typedef struct packed {
    logic [DATA_W-1:0]  rdata;
    logic [ID_IN_W-1:0] id;
  } ini_rsp_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0]   rdata;
    logic [ID_OUT_W-1:0] id;
  } tgt_rsp_chan_t;

  // Port bundles, one per driving side
  typedef struct packed {
    logic          req_valid;
    ini_req_chan_t req;
    logic          rsp_ready;
  } ini_req_t;

  typedef struct packed {
    logic          req_ready;
    logic          rsp_valid;
    ini_rsp_chan_t rsp;
  } ini_rsp_t;

  typedef struct packed {
    logic          req_valid;
    tgt_req_chan_t req;
    logic          rsp_ready;
  } tgt_req_t;

  typedef struct packed {
    logic          req_ready;
    logic          rsp_valid;
    tgt_rsp_chan_t rsp;
  } tgt_rsp_t;

endpackage

// File: cluster_bus_spill.sv
`timescale 1ns/1ps

module cluster_bus_spill #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full_q;
  payload_t data_q;
  logic     load;

  // Stage can take a new item while the old one leaves
  assign ready_o = !full_q || ready_i;
  assign load    = valid_i && ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (load) begin
      full_q <= 1'b1;
    end else if (ready_i) begin
      full_q <= 1'b0;     // Drained with nothing behind it
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full_q;
  assign data_o  = data_q;

  // A stalled item must neither vanish nor change
  a_stall_stable : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    valid_o && !ready_i |=> valid_o && $stable(data_o)
  ) else $error("spill output changed while stalled");

endmodule

// File: cluster_bus_wrap.sv
`timescale 1ns/1ps

module cluster_bus_wrap #(
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] BASE_ADDR   = 32'h1000_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] PERIPH_OFFS = 32'h0020_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] EXT_OFFS    = 32'h0040_0000,
  parameter logic [cluster_bus_pkg::ADDR_W-1:0] TCDM_SIZE   = 32'h0002_0000,
  parameter int unsigned                        MAX_OUTST   = 4
) (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  input  logic [cluster_bus_pkg::CLUSTER_ID_W-1:0] cluster_id_i,
  // Initiator ports
  input  cluster_bus_pkg::ini_req_t                data_req_i,
  output cluster_bus_pkg::ini_rsp_t                data_rsp_o,
  input  cluster_bus_pkg::ini_req_t                instr_req_i,
  output cluster_bus_pkg::ini_rsp_t                instr_rsp_o,
  input  cluster_bus_pkg::ini_req_t                dma_req_i,
  output cluster_bus_pkg::ini_rsp_t                dma_rsp_o,
  input  cluster_bus_pkg::ini_req_t                ext_req_i,
  output cluster_bus_pkg::ini_rsp_t                ext_rsp_o,
  // Target ports
  output cluster_bus_pkg::tgt_req_t                tcdm_req_o,
  input  cluster_bus_pkg::tgt_rsp_t                tcdm_rsp_i,
  output cluster_bus_pkg::tgt_req_t                periph_req_o,
  input  cluster_bus_pkg::tgt_rsp_t                periph_rsp_i,
  output cluster_bus_pkg::tgt_req_t                ext_req_o,
  input  cluster_bus_pkg::tgt_rsp_t                ext_rsp_i
);

  import cluster_bus_pkg::*;

  if (TCDM_SIZE == 0) $fatal(1, "TCDM size must be non-zero");
  if (TCDM_SIZE > PERIPH_OFFS) $fatal(1, "TCDM window overlaps the peripheral window");
  if (MAX_OUTST == 0) $fatal(1, "at least one outstanding request is needed");

  ini_req_t [NB_INI-1:0]             ini_reqs;
  ini_rsp_t [NB_INI-1:0]             ini_rsps;
  ini_req_t [NB_INI-1:0][NB_TGT-1:0] dmx_req;   // Indexed [initiator][target]
  ini_rsp_t [NB_INI-1:0][NB_TGT-1:0] dmx_rsp;
  ini_req_t [NB_TGT-1:0][NB_INI-1:0] mux_req;   // Indexed [target][initiator]
  ini_rsp_t [NB_TGT-1:0][NB_INI-1:0] mux_rsp;
  tgt_req_t [NB_TGT-1:0]             tgt_reqs;
  tgt_rsp_t [NB_TGT-1:0]             tgt_rsps;

  // Initiator order sets the ID tag: data, instr, DMA, external
  assign ini_reqs[0] = data_req_i;
  assign ini_reqs[1] = instr_req_i;
  assign ini_reqs[2] = dma_req_i;
  assign ini_reqs[3] = ext_req_i;
  assign data_rsp_o  = ini_rsps[0];
  assign instr_rsp_o = ini_rsps[1];
  assign dma_rsp_o   = ini_rsps[2];
  assign ext_rsp_o   = ini_rsps[3];

  assign tcdm_req_o            = tgt_reqs[TGT_TCDM];
  assign periph_req_o          = tgt_reqs[TGT_PERIPH];
  assign ext_req_o             = tgt_reqs[TGT_EXT];
  assign tgt_rsps[TGT_TCDM]    = tcdm_rsp_i;
  assign tgt_rsps[TGT_PERIPH]  = periph_rsp_i;
  assign tgt_rsps[TGT_EXT]     = ext_rsp_i;

  for (genvar i = 0; i < NB_INI; i++) begin : g_ini
    cluster_bus_demux #(
      .BASE_ADDR   (BASE_ADDR),
      .PERIPH_OFFS (PERIPH_OFFS),
      .EXT_OFFS    (EXT_OFFS),
      .TCDM_SIZE   (TCDM_SIZE),
      .MAX_OUTST   (MAX_OUTST)
    ) u_demux (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cluster_id_i (cluster_id_i),
      .ini_req_i    (ini_reqs[i]),
      .ini_rsp_o    (ini_rsps[i]),
      .tgt_req_o    (dmx_req[i]),
      .tgt_rsp_i    (dmx_rsp[i])
    );

    for (genvar t = 0; t < NB_TGT; t++) begin : g_xpose
      assign mux_req[t][i] = dmx_req[i][t];
      assign dmx_rsp[i][t] = mux_rsp[t][i];
    end
  end

  for (genvar t = 0; t < NB_TGT; t++) begin : g_tgt
    cluster_bus_mux u_mux (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .ini_req_i (mux_req[t]),
      .ini_rsp_o (mux_rsp[t]),
      .tgt_req_o (tgt_reqs[t]),
      .tgt_rsp_i (tgt_rsps[t])
    );
  end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the cluster bus testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cluster_bus -f build.f -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Checks failed" sim.log; then
  exit 1
fi
exit 0

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: tb_cluster_bus.sv
`timescale 1ns/1ps

module tb_cluster_bus;

  import cluster_bus_pkg::*;

  localparam logic [31:0] BASE_ADDR   = 32'h1000_0000;
  localparam logic [31:0] PERIPH_OFFS = 32'h0020_0000;
  localparam logic [31:0] EXT_OFFS    = 32'h0040_0000;
  localparam logic [31:0] TCDM_SIZE   = 32'h0002_0000;
  localparam logic [5:0]  CLUSTER_ID  = 6'd3;
  localparam logic [31:0] CL_BASE     = BASE_ADDR + (32'(CLUSTER_ID) << 22);
  localparam logic [31:0] EXT_AREA    = 32'h2000_0000;  // Well above the cluster
  localparam int          TIMEOUT     = 2000;

  logic          clk;
  logic          rst_n;
  logic          vld_d [4];
  ini_req_chan_t req_d [4];
  logic          rsp_rdy [4];
  ini_req_t      ini_req [4];
  ini_rsp_t      ini_rsp [4];
  tgt_req_t      tgt_req [3];
  tgt_rsp_t      tgt_rsp [3];

  logic        bp_on = 1'b0;   // Random rsp_ready on the initiator side
  logic        started = 1'b0;
  logic [31:0] tgt_rng;
  logic [31:0] stim_rng = 32'hea99_11ab;
  int          errs = 0;
  int          checks = 0;
  int          tests = 0;
  int          err_base = 0;

  // Expected responses per initiator in issue order
  logic [3:0]  exp_id [4][16];
  logic [31:0] exp_data [4][16];
  int          exp_hd [4];
  int          exp_tl [4];
  int          sent [4];
  int          recv [4];
  logic [31:0] ref_mem [logic [31:0]];

  // Target model state
  logic [31:0] tgt_mem [logic [31:0]];
  logic [31:0] q_data [3][16];
  logic [5:0]  q_id [3][16];
  int          q_hd [3];
  int          q_tl [3];

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clk (.clk_o(clk), .rst_n_o(rst_n));

  for (genvar g = 0; g < 4; g++) begin : g_ini
    assign ini_req[g] = '{req_valid: vld_d[g], req: req_d[g], rsp_ready: rsp_rdy[g]};
  end

  cluster_bus_wrap #(
    .BASE_ADDR   (BASE_ADDR),
    .PERIPH_OFFS (PERIPH_OFFS),
    .EXT_OFFS    (EXT_OFFS),
    .TCDM_SIZE   (TCDM_SIZE),
    .MAX_OUTST   (4)
  ) u_dut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .cluster_id_i (CLUSTER_ID),
    .data_req_i   (ini_req[0]),
    .data_rsp_o   (ini_rsp[0]),
    .instr_req_i  (ini_req[1]),
    .instr_rsp_o  (ini_rsp[1]),
    .dma_req_i    (ini_req[2]),
    .dma_rsp_o    (ini_rsp[2]),
    .ext_req_i    (ini_req[3]),
    .ext_rsp_o    (ini_rsp[3]),
    .tcdm_req_o   (tgt_req[0]),
    .tcdm_rsp_i   (tgt_rsp[0]),
    .periph_req_o (tgt_req[1]),
    .periph_rsp_i (tgt_rsp[1]),
    .ext_req_o    (tgt_req[2]),
    .ext_rsp_i    (tgt_rsp[2])
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_stim();
    stim_rng = xorshift32(stim_rng);
    return stim_rng;
  endfunction

  // Region map of cluster 3
  function automatic int tgt_of(input logic [31:0] addr);
    if (addr >= CL_BASE && addr < CL_BASE + TCDM_SIZE) return 0;
    if (addr >= CL_BASE + PERIPH_OFFS && addr < CL_BASE + EXT_OFFS) return 1;
    return 2;
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] addr);
    if (ref_mem.exists(addr)) return ref_mem[addr];
    return addr ^ 32'(tgt_of(addr));
  endfunction

  logic any_valid;
  always_comb begin
    any_valid = 1'b0;
    for (int t = 0; t < 3; t++) any_valid = any_valid | tgt_req[t].req_valid;
    for (int i = 0; i < 4; i++) any_valid = any_valid | ini_rsp[i].rsp_valid;
  end

  a_quiet_after_reset : assert property (
    @(posedge clk) disable iff (!rst_n) !started |-> !any_valid
  ) else begin
    errs++;
    $display("A valid output went high before any request was sent");
  end

  for (genvar t = 0; t < 3; t++) begin : g_tgt_chk
    a_route : assert property (
      @(posedge clk) disable iff (!rst_n)
      tgt_req[t].req_valid |-> tgt_of(tgt_req[t].req.addr) == t
    ) else begin
      errs++;
      $display("ERROR req.addr %h appeared on target %h", tgt_req[t].req.addr, t);
    end

    // Tests tag each ID with the sender index in its upper two bits
    a_id_widen : assert property (
      @(posedge clk) disable iff (!rst_n)
      tgt_req[t].req_valid |-> tgt_req[t].req.id[5:4] == tgt_req[t].req.id[3:2]
    ) else begin
      errs++;
      $display("ERROR req.id %h at target %h", tgt_req[t].req.id, t);
    end

    // Every request is sent with all byte lanes enabled
    a_be_full : assert property (
      @(posedge clk) disable iff (!rst_n)
      tgt_req[t].req_valid |-> tgt_req[t].req.be == 4'hf
    ) else begin
      errs++;
      $display("ERROR req.be %h expected %h", tgt_req[t].req.be, 4'hf);
    end

    a_req_stall : assert property (
      @(posedge clk) disable iff (!rst_n)
      tgt_req[t].req_valid && !tgt_rsp[t].req_ready |=>
        tgt_req[t].req_valid && $stable(tgt_req[t].req)
    ) else begin
      errs++;
      $display("Request at target %0d changed while stalled", t);
    end
  end

  for (genvar i = 0; i < 4; i++) begin : g_ini_chk
    a_rsp_stall : assert property (
      @(posedge clk) disable iff (!rst_n)
      ini_rsp[i].rsp_valid && !ini_req[i].rsp_ready |=>
        ini_rsp[i].rsp_valid && $stable(ini_rsp[i].rsp)
    ) else begin
      errs++;
      $display("Response at initiator %0d changed while stalled", i);
    end
  end

  // Target models and initiator rsp_ready
  initial begin : targets
    int          cnt;
    logic [31:0] rd;
    tgt_rng = 32'hea99_11ab;
    for (int t = 0; t < 3; t++) tgt_rsp[t] = '0;
    for (int i = 0; i < 4; i++) rsp_rdy[i] = 1'b1;
    forever begin
      @(posedge clk);
      for (int t = 0; t < 3; t++) begin
        if (tgt_req[t].req_valid && tgt_rsp[t].req_ready) begin
          if (tgt_req[t].req.we) begin
            tgt_mem[tgt_req[t].req.addr] = tgt_req[t].req.wdata;
            rd = tgt_req[t].req.wdata;   // Writes echo their data
          end else if (tgt_mem.exists(tgt_req[t].req.addr)) begin
            rd = tgt_mem[tgt_req[t].req.addr];
          end else begin
            rd = tgt_req[t].req.addr ^ 32'(t);
          end
          q_data[t][q_tl[t] % 16] = rd;
          q_id[t][q_tl[t] % 16] = tgt_req[t].req.id;
          q_tl[t]++;
        end
        if (tgt_rsp[t].rsp_valid && tgt_req[t].rsp_ready) q_hd[t]++;
        cnt = q_tl[t] - q_hd[t];
        tgt_rng = xorshift32(tgt_rng);
        tgt_rsp[t].rsp_valid <= (cnt != 0);
        tgt_rsp[t].rsp <= '{rdata: q_data[t][q_hd[t] % 16], id: q_id[t][q_hd[t] % 16]};
        tgt_rsp[t].req_ready <= (cnt < 8) && (tgt_rng[1:0] != 2'b00);
      end
      for (int i = 0; i < 4; i++) begin
        tgt_rng = xorshift32(tgt_rng);
        rsp_rdy[i] <= !bp_on || (tgt_rng[1:0] != 2'b00);
      end
    end
  end

  // Response checker per initiator in issue order
  initial begin : monitor
    int slot;
    forever begin
      @(posedge clk);
      for (int i = 0; i < 4; i++) begin
        if (rst_n && ini_rsp[i].rsp_valid && ini_req[i].rsp_ready) begin
          checks++;
          recv[i]++;
          if (exp_hd[i] == exp_tl[i]) begin
            errs++;
            $display("Initiator %0d got a response with no request outstanding", i);
          end else begin
            slot = exp_hd[i] % 16;
            assert (ini_rsp[i].rsp.id == exp_id[i][slot]) else begin
              errs++;
              $display("ERROR rsp.id %h expected %h", ini_rsp[i].rsp.id, exp_id[i][slot]);
            end
            assert (ini_rsp[i].rsp.rdata == exp_data[i][slot]) else begin
              errs++;
              $display("ERROR rsp.rdata %h expected %h",
                       ini_rsp[i].rsp.rdata, exp_data[i][slot]);
            end
            exp_hd[i]++;
          end
        end
      end
    end
  end

  task automatic abort_run(input string what);
    $display("Timeout: %s", what);
    $display("Checks failed");
    $finish;
  endtask

  task automatic send(input int i, input logic [31:0] addr, input logic we,
                      input logic [31:0] wdata, input logic [3:0] id);
    int n;
    exp_id[i][exp_tl[i] % 16] = id;
    exp_data[i][exp_tl[i] % 16] = we ? wdata : ref_read(addr);
    if (we) ref_mem[addr] = wdata;
    exp_tl[i]++;
    sent[i]++;
    started = 1'b1;
    vld_d[i] <= 1'b1;
    req_d[i] <= '{addr: addr, we: we, wdata: wdata, be: 4'hf, id: id};
    n = 0;
    forever begin
      @(posedge clk);
      if (ini_rsp[i].req_ready) break;
      n++;
      if (n > TIMEOUT) abort_run("request was never accepted");
    end
    vld_d[i] <= 1'b0;
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_hd[0] != exp_tl[0] || exp_hd[1] != exp_tl[1] ||
           exp_hd[2] != exp_tl[2] || exp_hd[3] != exp_tl[3]) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) abort_run("responses did not all return");
    end
  endtask

  // Random reads and writes in a slice owned by initiator i
  task automatic burst(input int i, input bit mixed);
    logic [31:0] r;
    logic [31:0] base;
    int          tg;
    for (int k = 0; k < 12; k++) begin
      r = next_stim();
      tg = mixed ? int'(r[9:8]) % 3 : 0;
      base = (tg == 0) ? CL_BASE : (tg == 1) ? CL_BASE + PERIPH_OFFS : EXT_AREA;
      send(i, base + 32'(i) * 32'h1000 + 32'({r[7:2], 2'b00}), r[12],
           r ^ 32'h5a5a_0000, {2'(i), 2'(k)});
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %-12s %0d errors", name, errs - err_base);
    err_base = errs;
  endtask

  initial begin : main
    int n;
    for (int i = 0; i < 4; i++) begin
      vld_d[i] = 1'b0;
      req_d[i] = '0;
    end
    n = 0;
    while (!rst_n) begin
      @(posedge clk);
      n++;
      if (n > 100) abort_run("reset never released");
    end

    repeat (6) @(posedge clk);   // Outputs stay quiet while idle
    end_test("reset_idle");

    for (int i = 0; i < 4; i++) begin
      send(i, CL_BASE, 1'b0, '0, {2'(i), 2'd0});
      send(i, CL_BASE + TCDM_SIZE - 4, 1'b0, '0, {2'(i), 2'd1});
      send(i, CL_BASE + PERIPH_OFFS + 32'h10, 1'b0, '0, {2'(i), 2'd2});
      send(i, CL_BASE + EXT_OFFS + 32'h40, 1'b0, '0, {2'(i), 2'd3});
      send(i, 32'h0, 1'b0, '0, {2'(i), 2'd0});
    end
    wait_drain();
    end_test("routing");

    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 4; k++) begin
        send(i, CL_BASE + PERIPH_OFFS + 32'(i << 8) + 32'(k << 2), 1'b0, '0, {2'(i), 2'(k)});
      end
    end
    wait_drain();
    end_test("id_restore");

    send(0, CL_BASE + 32'h100, 1'b1, 32'hcafe_0001, 4'h1);
    send(0, CL_BASE + 32'h100, 1'b0, '0, 4'h2);
    send(1, CL_BASE + PERIPH_OFFS + 32'h8, 1'b1, 32'hbeef_0002, 4'h5);
    send(1, CL_BASE + PERIPH_OFFS + 32'h8, 1'b0, '0, 4'h6);
    send(2, EXT_AREA + 32'h40, 1'b1, 32'h1234_5678, 4'h9);
    send(2, EXT_AREA + 32'h40, 1'b0, '0, 4'ha);
    send(3, EXT_AREA + 32'h80, 1'b0, '0, 4'hd);
    send(3, CL_BASE + 32'h200, 1'b0, '0, 4'he);
    wait_drain();
    end_test("read_write");

    fork
      burst(0, 1'b0);
      burst(1, 1'b0);
      burst(2, 1'b0);
      burst(3, 1'b0);
    join
    wait_drain();
    for (int i = 0; i < 4; i++) begin
      assert (sent[i] == recv[i]) else begin
        errs++;
        $display("ERROR recv %h expected %h", recv[i], sent[i]);
      end
    end
    end_test("tcdm_bursts");

    bp_on = 1'b1;
    fork
      burst(0, 1'b1);
      burst(1, 1'b1);
      burst(2, 1'b1);
      burst(3, 1'b1);
    join
    wait_drain();
    for (int i = 0; i < 4; i++) begin
      assert (sent[i] == recv[i]) else begin
        errs++;
        $display("ERROR recv %h expected %h", recv[i], sent[i]);
      end
    end
    end_test("backpressure");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errs);
    if (errs == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule
